// ==== project.f ====
logic/predictor_pkg.sv
logic/fetch_pkg.sv
logic/fetch_pc.sv
logic/pattern_table.sv
logic/target_buffer.sv
logic/gshare_predictor.sv
logic/gshare_fetch_top.sv
test/clock_gen.sv
test/gshare_fetch_assertions.sv
test/tb_gshare_fetch.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator; the log decides pass or fail
rm -f sim.log
verilator --binary --timing --assert --top-module tb_gshare_fetch -f project.f \
    -o sim_gshare_fetch && ./obj_dir/sim_gshare_fetch > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || exit 1
exit 0

// ==== test/tb_gshare_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_gshare_fetch;

    import fetch_pkg::*;
    import predictor_pkg::*;

    // Random branch with two targets, loop-back branch and trained branch
    localparam pc_t RAND_PC   = 32'h18;
    localparam pc_t RAND_T    = 32'h04;
    localparam pc_t RAND_T2   = 32'h08;
    localparam pc_t LOOP_PC   = 32'h1c;
    localparam pc_t TRAIN_PC  = 32'h40;
    localparam pc_t TRAIN_T   = 32'h20;
    localparam int  RANDOM_CYCLES = 120;
    localparam int  MAX_CYCLES    = 400;

    logic        clk;
    logic        rst_n;
    logic        hold;
    resolve_t    resolve_drv;
    fetch_t      fetch;
    logic        flush;
    logic [31:0] lfsr_q;
    int          cycle_count = 0;
    int          train_count;

    clock_gen clock_gen_inst (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    gshare_fetch_top #(
        .BTB_INDEX_WIDTH (4)
    ) gshare_fetch_top_inst (
        .clk_i     (clk),
        .rst_ni    (rst_n),
        .hold_i    (hold),
        .resolve_i (resolve_drv),
        .fetch_o   (fetch),
        .flush_o   (flush)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic next_random_bit(output logic bit_o);
        bit_o  = lfsr_q[0];
        lfsr_q = lfsr_step(lfsr_q);
    endtask

    // Resolve the record on fetch_o as it stands
    task automatic resolve_fetched(input logic taken, input pc_t target);
        resolve_drv.valid      = 1'b1;
        resolve_drv.pc         = fetch.pc;
        resolve_drv.taken      = taken;
        resolve_drv.target     = target;
        resolve_drv.prediction = fetch.prediction;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Done: errors found");
            $fatal(1, "Timeout: run did not finish within the cycle limit");
        end
    end

    always @(negedge clk) begin
        if (gshare_fetch_top_inst.assertions_inst.any_failed) begin
            $display("Done: errors found");
            $fatal(1, "An assertion in the monitor failed");
        end
    end

    initial begin
        logic h0;
        logic h1;
        logic outcome;
        logic alt_target;
        hold        = 1'b0;
        resolve_drv = '0;
        lfsr_q      = 32'h2df4168f;
        train_count = 0;
        @(posedge rst_n);
        step_cycle();

        // Random hold, outcomes and targets on a two-branch loop
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            next_random_bit(h0);
            next_random_bit(h1);
            hold        = h0 & h1;
            resolve_drv = '0;
            if (fetch.pc == RAND_PC) begin
                next_random_bit(outcome);
                next_random_bit(alt_target);
                resolve_fetched(outcome, alt_target ? RAND_T2 : RAND_T);
            end else if (fetch.pc == LOOP_PC) begin
                resolve_fetched(1'b1, 32'h0);
            end
            step_cycle();
        end

        // Leave the loop, then train one branch taken
        hold = 1'b0;
        while (train_count < 7) begin
            resolve_drv = '0;
            if (fetch.pc == RAND_PC || fetch.pc == LOOP_PC) begin
                resolve_fetched(1'b0, fetch.pc + 32'd4);
            end else if (fetch.pc == TRAIN_PC) begin
                resolve_fetched(1'b1, TRAIN_T);
                train_count++;
            end
            step_cycle();
        end
        resolve_drv = '0;
        repeat (4) step_cycle();
        @(negedge clk);

        if (gshare_fetch_top_inst.assertions_inst.any_failed) begin
            $display("Done: errors found");
            $fatal(1, "An assertion in the monitor failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== test/gshare_fetch_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module gshare_fetch_assertions (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    hold_i,
    input predictor_pkg::resolve_t resolve_i,
    input fetch_pkg::fetch_t       fetch_i,
    input logic                    flush_i
);

    import fetch_pkg::*;
    import predictor_pkg::*;

    // Taken resolves in a row needed to fill history and train the counter
    localparam int unsigned TRAIN_RUN = 6;

    logic fail_reset = 1'b0;
    logic fail_seq = 1'b0;
    logic fail_hold = 1'b0;
    logic fail_flush = 1'b0;
    logic fail_repair = 1'b0;
    logic fail_quiet = 1'b0;
    logic fail_redirect = 1'b0;
    logic fail_hit = 1'b0;
    logic fail_trained = 1'b0;
    logic any_failed;

    logic       mispredict;
    pc_t        repair_expect;
    pc_t        last_pc_q;
    pc_t        last_target_q;
    logic [2:0] run_q;
    logic       trained_fetch;

    assign any_failed = fail_reset | fail_seq | fail_hold | fail_flush | fail_repair
                        | fail_quiet | fail_redirect | fail_hit | fail_trained;

    // Wrong direction, or taken both ways to different targets
    assign mispredict = resolve_i.valid
        && ((resolve_i.taken != resolve_i.prediction.taken)
            || (resolve_i.taken && resolve_i.prediction.taken
                && (resolve_i.target != resolve_i.prediction.target)));
    assign repair_expect = resolve_i.taken ? resolve_i.target : resolve_i.pc + 32'd4;

    // Length of the current run of identical taken resolves
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            run_q         <= '0;
            last_pc_q     <= '0;
            last_target_q <= '0;
        end else if (resolve_i.valid) begin
            if (!resolve_i.taken) begin
                run_q <= '0;
            end else if (run_q != 0 && resolve_i.pc == last_pc_q
                         && resolve_i.target == last_target_q) begin
                if (run_q != 3'd7) begin
                    run_q <= run_q + 3'd1;
                end
            end else begin
                run_q         <= 3'd1;
                last_pc_q     <= resolve_i.pc;
                last_target_q <= resolve_i.target;
            end
        end
    end

    assign trained_fetch = (run_q >= TRAIN_RUN) && (fetch_i.pc == last_pc_q);

    reset_state: assert property (@(posedge clk_i) $rose(rst_ni) |->
        (fetch_i.pc == '0 && !flush_i && !fetch_i.prediction.btb_hit
         && !fetch_i.prediction.taken && fetch_i.prediction.history == '0))
        else begin
            fail_reset = 1'b1;
            $error("Error: fetch_o.pc=%h flush_o=%h btb_hit=%h taken=%h history=%h after reset",
                   fetch_i.pc, flush_i, fetch_i.prediction.btb_hit,
                   fetch_i.prediction.taken, fetch_i.prediction.history);
        end

    seq_advance: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!hold_i && !resolve_i.valid && !fetch_i.prediction.taken)
        |=> fetch_i.pc == $past(fetch_i.pc) + 32'd4)
        else begin
            fail_seq = 1'b1;
            $error("Error: fetch_o.pc=%h expected %h", fetch_i.pc, $past(fetch_i.pc) + 32'd4);
        end

    hold_freeze: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (hold_i && !mispredict) |=> fetch_i.pc == $past(fetch_i.pc))
        else begin
            fail_hold = 1'b1;
            $error("Error: fetch_o.pc=%h expected %h", fetch_i.pc, $past(fetch_i.pc));
        end

    flush_on_mispredict: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mispredict |-> flush_i)
        else begin
            fail_flush = 1'b1;
            $error("Error: flush_o=%h expected 1 for resolve of pc %h", flush_i, resolve_i.pc);
        end

    repair_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mispredict |=> fetch_i.pc == $past(repair_expect))
        else begin
            fail_repair = 1'b1;
            $error("Error: fetch_o.pc=%h expected %h", fetch_i.pc, $past(repair_expect));
        end

    quiet_on_correct: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (resolve_i.valid && !mispredict) |-> !flush_i)
        else begin
            fail_quiet = 1'b1;
            $error("Error: flush_o=%h expected 0 for resolve of pc %h", flush_i, resolve_i.pc);
        end

    predicted_redirect: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fetch_i.prediction.taken && !mispredict && !hold_i)
        |=> fetch_i.pc == $past(fetch_i.prediction.target))
        else begin
            fail_redirect = 1'b1;
            $error("Error: fetch_o.pc=%h expected %h", fetch_i.pc,
                   $past(fetch_i.prediction.target));
        end

    taken_needs_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_i.prediction.taken |-> fetch_i.prediction.btb_hit)
        else begin
            fail_hit = 1'b1;
            $error("Error: btb_hit=%h expected 1 with predicted taken",
                   fetch_i.prediction.btb_hit);
        end

    // Trained branch must predict its target from a full history
    trained_predicts: assert property (@(posedge clk_i) disable iff (!rst_ni)
        trained_fetch |-> (fetch_i.prediction.taken && fetch_i.prediction.history == '1
                           && fetch_i.prediction.target == last_target_q && !flush_i))
        else begin
            fail_trained = 1'b1;
            $error("Error: trained taken=%h history=%h target=%h flush_o=%h expected target %h",
                   fetch_i.prediction.taken, fetch_i.prediction.history,
                   fetch_i.prediction.target, flush_i, last_target_q);
        end

endmodule

bind gshare_fetch_top gshare_fetch_assertions assertions_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .hold_i    (hold_i),
    .resolve_i (resolve_i),
    .fetch_i   (fetch_o),
    .flush_i   (flush_o)
);

`default_nettype wire

// ==== test/clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int unsigned RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_no
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== logic/gshare_fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module gshare_fetch_top #(
    parameter int unsigned BTB_INDEX_WIDTH = 4
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    hold_i,
    input  predictor_pkg::resolve_t resolve_i,
    output fetch_pkg::fetch_t       fetch_o,
    output logic                    flush_o
);

    import fetch_pkg::*;
    import predictor_pkg::*;

    pc_t          pc;
    pc_t          repair_pc;
    prediction_t  prediction;
    next_pc_sel_e sel;

    fetch_pc fetch_pc_inst (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .hold_i             (hold_i),
        .sel_i              (sel),
        .predicted_target_i (prediction.target),
        .repair_pc_i        (repair_pc),
        .pc_o               (pc)
    );

    gshare_predictor #(
        .BTB_INDEX_WIDTH (BTB_INDEX_WIDTH)
    ) gshare_predictor_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pc_i         (pc),
        .resolve_i    (resolve_i),
        .prediction_o (prediction),
        .sel_o        (sel),
        .repair_pc_o  (repair_pc),
        .flush_o      (flush_o)
    );

    // Record travels down the pipe with the fetched instruction
    assign fetch_o.pc         = pc;
    assign fetch_o.prediction = prediction;

endmodule

`default_nettype wire

// ==== logic/gshare_predictor.sv ====
`timescale 1ns/10ps
`default_nettype none

module gshare_predictor #(
    parameter int unsigned BTB_INDEX_WIDTH = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  fetch_pkg::pc_t             pc_i,
    input  predictor_pkg::resolve_t    resolve_i,
    output predictor_pkg::prediction_t prediction_o,
    output fetch_pkg::next_pc_sel_e    sel_o,
    output fetch_pkg::pc_t             repair_pc_o,
    output logic                       flush_o
);

    import fetch_pkg::*;
    import predictor_pkg::*;

    history_t history_q;
    history_t rd_index;
    history_t wr_index;
    logic     counter_taken;
    logic     btb_hit;
    pc_t      btb_target;
    logic     target_wrong;
    logic     mispredict;

    // gshare index for fetch uses live history, for update the fetched snapshot
    assign rd_index = pc_i[HISTORY_WIDTH+1:2] ^ history_q;
    assign wr_index = resolve_i.pc[HISTORY_WIDTH+1:2] ^ resolve_i.prediction.history;

    pattern_table pattern_table_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rd_index_i (rd_index),
        .taken_o    (counter_taken),
        .wr_en_i    (resolve_i.valid),
        .wr_index_i (wr_index),
        .outcome_i  (resolve_i.taken)
    );

    // Only taken branches allocate a target
    target_buffer #(
        .BTB_INDEX_WIDTH (BTB_INDEX_WIDTH)
    ) target_buffer_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_pc_i     (pc_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .wr_en_i     (resolve_i.valid && resolve_i.taken),
        .wr_pc_i     (resolve_i.pc),
        .wr_target_i (resolve_i.target)
    );

    // Taken needs a known target, so the BTB hit gates the counter
    assign prediction_o.btb_hit = btb_hit;
    assign prediction_o.taken   = btb_hit && counter_taken;
    assign prediction_o.history = history_q;
    assign prediction_o.target  = btb_target;

    assign target_wrong = resolve_i.taken && resolve_i.prediction.taken
                          && (resolve_i.target != resolve_i.prediction.target);

    assign mispredict = resolve_i.valid
                        && ((resolve_i.taken != resolve_i.prediction.taken) || target_wrong);

    always_comb begin
        if (mispredict) begin
            sel_o = resolve_i.taken ? SEL_REPAIR_TARGET : SEL_REPAIR_SEQ;
        end else if (prediction_o.taken) begin
            sel_o = SEL_PREDICTED;
        end else begin
            sel_o = SEL_SEQ;
        end
    end

    // fetch_pc adds 4 itself on the not-taken repair
    assign repair_pc_o = resolve_i.taken ? resolve_i.target : resolve_i.pc;
    assign flush_o     = mispredict;

    // Newest outcome enters at bit 0, updated at resolution only
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            history_q <= '0;
        end else if (resolve_i.valid) begin
            history_q <= {history_q[HISTORY_WIDTH-2:0], resolve_i.taken};
        end
    end

endmodule

`default_nettype wire

// ==== logic/target_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module target_buffer #(
    parameter int unsigned BTB_INDEX_WIDTH = 4
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  fetch_pkg::pc_t rd_pc_i,
    output logic           hit_o,
    output fetch_pkg::pc_t target_o,
    input  logic           wr_en_i,
    input  fetch_pkg::pc_t wr_pc_i,
    input  fetch_pkg::pc_t wr_target_i
);

    import fetch_pkg::*;

    localparam int unsigned ENTRIES   = 2 ** BTB_INDEX_WIDTH;
    localparam int unsigned TAG_WIDTH = PC_WIDTH - BTB_INDEX_WIDTH - 2;

    typedef logic [BTB_INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0]       tag_t;

    typedef struct packed {
        tag_t tag;
        pc_t  target;
    } entry_t;

    logic [ENTRIES-1:0] valid_q;
    entry_t             entries_q [ENTRIES];

    index_t rd_index;
    index_t wr_index;
    tag_t   rd_tag;
    entry_t rd_entry;
    entry_t wr_entry;

    // Word-aligned PC, index right above the byte offset
    assign rd_index = rd_pc_i[BTB_INDEX_WIDTH+1:2];
    assign rd_tag   = rd_pc_i[PC_WIDTH-1:BTB_INDEX_WIDTH+2];
    assign wr_index = wr_pc_i[BTB_INDEX_WIDTH+1:2];

    assign wr_entry.tag    = wr_pc_i[PC_WIDTH-1:BTB_INDEX_WIDTH+2];
    assign wr_entry.target = wr_target_i;

    assign rd_entry = entries_q[rd_index];
    assign hit_o    = valid_q[rd_index] && (rd_entry.tag == rd_tag);
    assign target_o = rd_entry.target;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            entries_q[wr_index] <= wr_entry;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pattern_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module pattern_table (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  predictor_pkg::history_t rd_index_i,
    output logic                    taken_o,
    input  logic                    wr_en_i,
    input  predictor_pkg::history_t wr_index_i,
    input  logic                    outcome_i
);

    import predictor_pkg::*;

    localparam int unsigned ENTRIES = 2 ** HISTORY_WIDTH;

    counter_e counters_q [ENTRIES];
    counter_e rd_count;
    counter_e wr_count;
    counter_e wr_count_next;

    assign rd_count = counters_q[rd_index_i];
    assign taken_o  = rd_count[1];

    assign wr_count = counters_q[wr_index_i];

    // One step toward the outcome, saturating at both ends
    always_comb begin
        wr_count_next = wr_count;
        case (wr_count)
            STRONG_NOT_TAKEN: begin
                if (outcome_i) begin
                    wr_count_next = WEAK_NOT_TAKEN;
                end
            end
            WEAK_NOT_TAKEN:   wr_count_next = outcome_i ? WEAK_TAKEN : STRONG_NOT_TAKEN;
            WEAK_TAKEN:       wr_count_next = outcome_i ? STRONG_TAKEN : WEAK_NOT_TAKEN;
            STRONG_TAKEN: begin
                if (!outcome_i) begin
                    wr_count_next = WEAK_TAKEN;
                end
            end
            default:          wr_count_next = WEAK_NOT_TAKEN;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters_q[i] <= WEAK_NOT_TAKEN;
            end
        end else if (wr_en_i) begin
            counters_q[wr_index_i] <= wr_count_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_pc.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_pc (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    hold_i,
    input  fetch_pkg::next_pc_sel_e sel_i,
    input  fetch_pkg::pc_t          predicted_target_i,
    input  fetch_pkg::pc_t          repair_pc_i,
    output fetch_pkg::pc_t          pc_o
);

    import fetch_pkg::*;

    pc_t  pc_q;
    pc_t  pc_next;
    pc_t  pc_plus4;
    pc_t  repair_plus4;
    logic repair;

    assign pc_plus4     = pc_q + PC_WIDTH'(4);
    // Resolved PC plus 4, only meaningful for SEL_REPAIR_SEQ
    assign repair_plus4 = repair_pc_i + PC_WIDTH'(4);

    assign repair = (sel_i == SEL_REPAIR_SEQ) || (sel_i == SEL_REPAIR_TARGET);

    always_comb begin
        case (sel_i)
            SEL_PREDICTED:     pc_next = predicted_target_i;
            SEL_REPAIR_SEQ:    pc_next = repair_plus4;
            SEL_REPAIR_TARGET: pc_next = repair_pc_i;
            default:           pc_next = pc_plus4;
        endcase
    end

    // Repair always loads, hold only freezes normal flow
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= '0;
        end else if (repair || !hold_i) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Instruction address width, same as the predictor's address
    localparam int unsigned PC_WIDTH = predictor_pkg::ADDR_WIDTH;

    typedef predictor_pkg::addr_t pc_t;

    // Next-PC multiplexer select
    typedef enum logic [1:0] {
        SEL_SEQ           = 2'd0,
        SEL_PREDICTED     = 2'd1,
        SEL_REPAIR_SEQ    = 2'd2,
        SEL_REPAIR_TARGET = 2'd3
    } next_pc_sel_e;

    // Fetched PC and the prediction made for it
    typedef struct packed {
        pc_t                        pc;
        predictor_pkg::prediction_t prediction;
    } fetch_t;

endpackage

`default_nettype wire

// ==== logic/predictor_pkg.sv ====
`default_nettype none

package predictor_pkg;

    // Address type used by both predictor and fetch records
    localparam int unsigned ADDR_WIDTH = 32;

    // Global history length, also the counter table index width
    localparam int unsigned HISTORY_WIDTH = 3;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [HISTORY_WIDTH-1:0] history_t;

    // 2-bit saturating counter, upper bit is the predicted direction
    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'b00,
        WEAK_NOT_TAKEN   = 2'b01,
        WEAK_TAKEN       = 2'b10,
        STRONG_TAKEN     = 2'b11
    } counter_e;

    // What fetch predicted for one PC
    typedef struct packed {
        logic     btb_hit;
        logic     taken;
        history_t history;
        addr_t    target;
    } prediction_t;

    // Branch outcome coming back from execute, with its fetch-time record
    typedef struct packed {
        logic        valid;
        addr_t       pc;
        logic        taken;
        addr_t       target;
        prediction_t prediction;
    } resolve_t;

endpackage

`default_nettype wire
